// ==== Bender.yml ====
package:
  name: ucpd_rx

sources:
  - files:
      - logic/ucpd_rx_pkg.sv
      - logic/ucpd_rx_symbol_shifter.sv
      - logic/ucpd_rx_sop_detect.sv
      - logic/ucpd_rx_data_decode.sv
      - logic/ucpd_rx_buffer.sv
      - logic/ucpd_rx_top.sv
  - target: test
    files:
      - test/ucpd_rx_tb.sv

// ==== logic/ucpd_rx_buffer.sv ====
// --------------------
// one-byte receive register seen by software
// no back-pressure, an unread byte is overwritten and flagged
// --------------------
`timescale 1ns/1ps

module ucpd_rx_buffer (
  input  logic                           ucpd_clk,
  input  logic                           ic_rst_n,
  input  logic                           rx_start,
  input  logic                           byte_vld,
  input  logic [ucpd_rx_pkg::BYTE_W-1:0] byte_val,
  input  logic                           eop,
  input  logic                           rxdr_rd,      // software read pulse
  output logic [ucpd_rx_pkg::BYTE_W-1:0] rx_byte,
  output logic                           rxne,         // not empty
  output logic                           rx_ovr,       // sticky until rx_start
  output logic                           msg_end,
  output logic [ucpd_rx_pkg::CNT_W-1:0]  rx_byte_cnt
);

  logic lost_byte;

  // byte arrives over one nobody has read
  assign lost_byte = byte_vld && rxne && !rxdr_rd;

  // data register
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      rx_byte <= '0;
    end else if (byte_vld) begin
      rx_byte <= byte_val;
    end
  end

  // flags --------------------
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      rxne    <= 1'b0;
      rx_ovr  <= 1'b0;
      msg_end <= 1'b0;
    end else begin
      msg_end <= eop;                  // end of message, one cycle late
      if (byte_vld) begin
        rxne <= 1'b1;                  // set beats a same-cycle read
      end else if (rxdr_rd) begin
        rxne <= 1'b0;
      end
      if (rx_start) begin
        rx_ovr <= 1'b0;
      end else if (lost_byte) begin
        rx_ovr <= 1'b1;
      end
    end
  end

  // payload size --------------------
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      rx_byte_cnt <= '0;
    end else if (rx_start) begin
      rx_byte_cnt <= '0;
    end else if (byte_vld) begin
      rx_byte_cnt <= rx_byte_cnt + 1'b1;
    end
  end

endmodule

// ==== logic/ucpd_rx_data_decode.sv ====
// --------------------
// 4b5b payload decode, first symbol of a pair is the low nibble
// active only in the data phase, an unpaired nibble is lost at eop
// --------------------
`timescale 1ns/1ps

module ucpd_rx_data_decode (
  input  logic                           ucpd_clk,
  input  logic                           ic_rst_n,
  input  logic                           data_en,    // data phase level
  input  logic                           sym_vld,
  input  logic [ucpd_rx_pkg::SYM_W-1:0]  sym,
  output logic                           byte_vld,
  output logic [ucpd_rx_pkg::BYTE_W-1:0] byte_val,
  output logic                           eop
);

  logic [ucpd_rx_pkg::NIB_W-1:0] nib;      // decoded current symbol
  logic [ucpd_rx_pkg::NIB_W-1:0] lo_nib;   // held low half
  logic                          hi_pend;  // low nibble waits for partner
  logic                          sym_eop;
  logic                          sym_take;

  assign nib      = ucpd_rx_pkg::decode_4b5b(sym);
  assign sym_eop  = (sym == ucpd_rx_pkg::KEOP);
  assign sym_take = data_en && sym_vld;

  // pair control --------------------
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      hi_pend  <= 1'b0;
      byte_vld <= 1'b0;
      eop      <= 1'b0;
    end else begin
      byte_vld <= 1'b0;
      eop      <= 1'b0;
      if (!data_en) begin
        hi_pend <= 1'b0;               // idle outside data phase
      end else if (sym_vld) begin
        if (sym_eop) begin
          eop     <= 1'b1;
          hi_pend <= 1'b0;             // drop odd nibble
        end else if (hi_pend) begin
          byte_vld <= 1'b1;            // pair complete
          hi_pend  <= 1'b0;
        end else begin
          hi_pend <= 1'b1;
        end
      end
    end
  end

  // payload --------------------
  always_ff @(posedge ucpd_clk) begin
    if (sym_take && !sym_eop) begin
      if (hi_pend) begin
        byte_val <= {nib, lo_nib};     // second symbol is the high nibble
      end else begin
        lo_nib <= nib;
      end
    end
  end

endmodule

// ==== logic/ucpd_rx_pkg.sv ====
// --------------------
// shared definitions for the usb pd receive path
// k-codes and data symbols hold the first received bit in bit 0
// --------------------
package ucpd_rx_pkg;

  // widths --------------------
  localparam int SYM_W       = 5;   // one line symbol
  localparam int NIB_W       = 4;   // decoded nibble
  localparam int BYTE_W      = 8;
  localparam int CNT_W       = 10;  // payload byte count
  localparam int SOP_KCODES  = 4;   // k-codes per ordered set
  localparam int ORDSET_EN_W = 6;   // enable bits, types 0 to 5

  // k-codes --------------------
  localparam logic [SYM_W-1:0] KSYNC1 = 5'b11000;
  localparam logic [SYM_W-1:0] KSYNC2 = 5'b10001;
  localparam logic [SYM_W-1:0] KSYNC3 = 5'b00110;
  localparam logic [SYM_W-1:0] KRST1  = 5'b00111;
  localparam logic [SYM_W-1:0] KRST2  = 5'b11001;
  localparam logic [SYM_W-1:0] KEOP   = 5'b01101;

  // ordered set type, order also sets match priority
  typedef enum logic [2:0] {
    os_sop        = 3'd0,
    os_sop_p      = 3'd1,
    os_sop_pp     = 3'd2,
    os_sop_p_dbg  = 3'd3,
    os_sop_pp_dbg = 3'd4,
    os_cable_rst  = 3'd5,
    os_hard_rst   = 3'd6,
    os_invalid    = 3'd7
  } ordset_e;

  // receive phase of the detector
  typedef enum logic [1:0] {
    ph_idle = 2'd0,   // waiting for rx_start
    ph_sop  = 2'd1,   // collecting k-codes
    ph_data = 2'd2    // payload until eop
  } rx_phase_e;

  // 4b5b data decode, anything outside the table gives zero
  function automatic logic [NIB_W-1:0] decode_4b5b(input logic [SYM_W-1:0] sym);
    logic [NIB_W-1:0] nib;
    nib = '0;
    case (sym)
      5'b11110: nib = 4'h0;
      5'b01001: nib = 4'h1;
      5'b10100: nib = 4'h2;
      5'b10101: nib = 4'h3;
      5'b01010: nib = 4'h4;
      5'b01011: nib = 4'h5;
      5'b01110: nib = 4'h6;
      5'b01111: nib = 4'h7;
      5'b10010: nib = 4'h8;
      5'b10011: nib = 4'h9;
      5'b10110: nib = 4'ha;
      5'b10111: nib = 4'hb;
      5'b11010: nib = 4'hc;
      5'b11011: nib = 4'hd;
      5'b11100: nib = 4'he;
      5'b11101: nib = 4'hf;
      default:  nib = 4'h0;   // k-codes and bad symbols
    endcase
    return nib;
  endfunction

endpackage

// ==== logic/ucpd_rx_sop_detect.sv ====
// --------------------
// ordered set detect with the three-of-four k-code rule
// hard reset always flags
// disabled or invalid sets drop back to idle
// --------------------
`timescale 1ns/1ps

module ucpd_rx_sop_detect (
  input  logic                                ucpd_clk,
  input  logic                                ic_rst_n,
  input  logic                                rx_start,
  input  logic                                sym_vld,
  input  logic [ucpd_rx_pkg::SYM_W-1:0]       sym,
  input  logic                                eop,
  input  logic [ucpd_rx_pkg::ORDSET_EN_W-1:0] ordset_en,
  output logic                                data_en,
  output logic                                ordset_vld,
  output ucpd_rx_pkg::ordset_e                ordset_type,
  output logic [2:0]                          corrupt_idx,
  output logic                                hrst_det
);

  localparam int SETW = ucpd_rx_pkg::SOP_KCODES * ucpd_rx_pkg::SYM_W;

  ucpd_rx_pkg::rx_phase_e        phase;
  logic [1:0]                    sym_idx;                  // k-code position
  logic [ucpd_rx_pkg::SYM_W-1:0] kc [ucpd_rx_pkg::SOP_KCODES-1]; // first three k-codes
  logic [SETW-1:0]               cand;                     // k1 in low bits
  ucpd_rx_pkg::ordset_e          best_type;
  logic [2:0]                    best_idx;
  logic                          last_kc;
  logic                          en_hit;

  // k-code pattern per type with position 1 in the low bits
  function automatic logic [SETW-1:0] ordset_pat(input int t);
    logic [SETW-1:0] pat;
    case (t)
      0: pat = {ucpd_rx_pkg::KSYNC2, ucpd_rx_pkg::KSYNC1,
                ucpd_rx_pkg::KSYNC1, ucpd_rx_pkg::KSYNC1};
      1: pat = {ucpd_rx_pkg::KSYNC3, ucpd_rx_pkg::KSYNC3,
                ucpd_rx_pkg::KSYNC1, ucpd_rx_pkg::KSYNC1};
      2: pat = {ucpd_rx_pkg::KSYNC3, ucpd_rx_pkg::KSYNC1,
                ucpd_rx_pkg::KSYNC3, ucpd_rx_pkg::KSYNC1};
      3: pat = {ucpd_rx_pkg::KSYNC3, ucpd_rx_pkg::KRST2,
                ucpd_rx_pkg::KRST2, ucpd_rx_pkg::KSYNC1};
      4: pat = {ucpd_rx_pkg::KSYNC2, ucpd_rx_pkg::KSYNC3,
                ucpd_rx_pkg::KRST2, ucpd_rx_pkg::KSYNC1};
      5: pat = {ucpd_rx_pkg::KSYNC3, ucpd_rx_pkg::KRST1,
                ucpd_rx_pkg::KSYNC1, ucpd_rx_pkg::KRST1};
      default: pat = {ucpd_rx_pkg::KRST2, ucpd_rx_pkg::KRST1,
                      ucpd_rx_pkg::KRST1, ucpd_rx_pkg::KRST1};   // hard reset
    endcase
    return pat;
  endfunction

  assign cand    = {sym, kc[2], kc[1], kc[0]};   // fourth k-code straight from input
  assign last_kc = sym_vld && (sym_idx == 2'(ucpd_rx_pkg::SOP_KCODES - 1));
  assign data_en = (phase == ucpd_rx_pkg::ph_data);

  // classifier --------------------
  always_comb begin : classify
    logic [SETW-1:0] pat;
    logic [2:0]      hits;
    logic [2:0]      miss_pos;
    logic            found;
    best_type = ucpd_rx_pkg::os_invalid;
    best_idx  = 3'd7;                  // no type matched
    found     = 1'b0;
    for (int t = 0; t < 7; t++) begin
      pat      = ordset_pat(t);
      hits     = 3'd0;
      miss_pos = 3'd0;
      for (int p = 0; p < ucpd_rx_pkg::SOP_KCODES; p++) begin
        if (cand[p*ucpd_rx_pkg::SYM_W +: ucpd_rx_pkg::SYM_W] ==
            pat[p*ucpd_rx_pkg::SYM_W +: ucpd_rx_pkg::SYM_W]) begin
          hits = hits + 3'd1;
        end else begin
          miss_pos = 3'(p + 1);        // 1-based position
        end
      end
      if (!found && hits >= 3'd3) begin  // lowest type wins
        found     = 1'b1;
        best_type = ucpd_rx_pkg::ordset_e'(t);
        best_idx  = miss_pos;          // stays 0 when all four agree
      end
    end
  end

  // only types 0 to 5 have an enable bit
  assign en_hit = (int'(best_type) < ucpd_rx_pkg::ORDSET_EN_W) ? ordset_en[best_type] : 1'b0;

  // phase machine --------------------
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      phase       <= ucpd_rx_pkg::ph_idle;
      sym_idx     <= '0;
      ordset_vld  <= 1'b0;
      hrst_det    <= 1'b0;
      ordset_type <= ucpd_rx_pkg::os_sop;
      corrupt_idx <= '0;
    end else begin
      ordset_vld <= 1'b0;
      hrst_det   <= 1'b0;
      if (rx_start) begin
        phase   <= ucpd_rx_pkg::ph_sop;  // restart from any phase
        sym_idx <= '0;
      end else begin
        case (phase)
          ucpd_rx_pkg::ph_sop: begin
            if (last_kc) begin
              ordset_type <= best_type;
              corrupt_idx <= best_idx;
              if (best_type == ucpd_rx_pkg::os_hard_rst) begin
                hrst_det <= 1'b1;
                phase    <= ucpd_rx_pkg::ph_idle;
              end else if (en_hit) begin
                ordset_vld <= 1'b1;
                phase      <= ucpd_rx_pkg::ph_data;
              end else begin
                phase <= ucpd_rx_pkg::ph_idle; // invalid or masked
              end
            end else if (sym_vld) begin
              sym_idx <= sym_idx + 2'd1;
            end
          end
          ucpd_rx_pkg::ph_data: begin
            if (eop) phase <= ucpd_rx_pkg::ph_idle;
          end
          default: ;                       // idle waits for rx_start
        endcase
      end
    end
  end

  // k-code store
  always_ff @(posedge ucpd_clk) begin
    if (phase == ucpd_rx_pkg::ph_sop && sym_vld && !last_kc && !rx_start) begin
      kc[sym_idx] <= sym;
    end
  end

endmodule

// ==== logic/ucpd_rx_symbol_shifter.sv ====
// --------------------
// packs strobed bmc bits into 5-bit symbols
// rx_start realigns the symbol boundary, the count wraps after that
// --------------------
`timescale 1ns/1ps

module ucpd_rx_symbol_shifter (
  input  logic                          ucpd_clk,
  input  logic                          ic_rst_n,
  input  logic                          rx_start,   // end of preamble
  input  logic                          rx_bit_vld, // one-cycle bit strobe
  input  logic                          rx_bit,
  output logic                          sym_vld,
  output logic [ucpd_rx_pkg::SYM_W-1:0] sym
);

  logic [ucpd_rx_pkg::SYM_W-1:0] shift_q;   // partial symbol
  logic [2:0]                    bit_cnt;   // bits taken so far
  logic [ucpd_rx_pkg::SYM_W-1:0] shift_nxt;
  logic                          last_bit;

  // new bit enters at the top, first bit drifts down to bit 0
  assign shift_nxt = {rx_bit, shift_q[ucpd_rx_pkg::SYM_W-1:1]};
  assign last_bit  = rx_bit_vld && (bit_cnt == 3'(ucpd_rx_pkg::SYM_W - 1));

  // bit counter --------------------
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      bit_cnt <= '0;
      sym_vld <= 1'b0;
    end else begin
      sym_vld <= 1'b0;
      if (rx_start) begin
        bit_cnt <= '0;                 // realign on start
      end else if (last_bit) begin
        bit_cnt <= '0;                 // wrap, next symbol follows
        sym_vld <= 1'b1;
      end else if (rx_bit_vld) begin
        bit_cnt <= bit_cnt + 3'd1;
      end
    end
  end

  // shift register and symbol output
  always_ff @(posedge ucpd_clk) begin
    if (rx_bit_vld) begin
      shift_q <= shift_nxt;
    end
    if (last_bit && !rx_start) begin
      sym <= shift_nxt;              // includes the fifth bit
    end
  end

endmodule

// ==== logic/ucpd_rx_top.sv ====
// --------------------
// usb pd receive path, single ucpd_clk domain
// bits come in already bmc decoded, rx_start marks the end of preamble
// --------------------
`timescale 1ns/1ps

module ucpd_rx_top (
  input  logic                                ucpd_clk,
  input  logic                                ic_rst_n,
  input  logic                                rx_start,
  input  logic                                rx_bit_vld,
  input  logic                                rx_bit,
  input  logic [ucpd_rx_pkg::ORDSET_EN_W-1:0] ordset_en,
  input  logic                                rxdr_rd,
  output logic [ucpd_rx_pkg::BYTE_W-1:0]      rx_byte,
  output logic                                rxne,
  output logic                                rx_ovr,
  output logic                                msg_end,
  output logic [ucpd_rx_pkg::CNT_W-1:0]       rx_byte_cnt,
  output logic                                ordset_vld,
  output ucpd_rx_pkg::ordset_e                ordset_type,
  output logic [2:0]                          corrupt_idx,
  output logic                                hrst_det
);

  logic                           sym_vld;
  logic [ucpd_rx_pkg::SYM_W-1:0]  sym;
  logic                           data_en;   // detector in data phase
  logic                           eop;
  logic                           byte_vld;
  logic [ucpd_rx_pkg::BYTE_W-1:0] byte_val;

  // bits to symbols
  ucpd_rx_symbol_shifter shifter_i (
    .ucpd_clk   (ucpd_clk),
    .ic_rst_n   (ic_rst_n),
    .rx_start   (rx_start),
    .rx_bit_vld (rx_bit_vld),
    .rx_bit     (rx_bit),
    .sym_vld    (sym_vld),
    .sym        (sym)
  );

  // ordered set and phase tracking
  ucpd_rx_sop_detect sop_detect_i (
    .ucpd_clk    (ucpd_clk),
    .ic_rst_n    (ic_rst_n),
    .rx_start    (rx_start),
    .sym_vld     (sym_vld),
    .sym         (sym),
    .eop         (eop),
    .ordset_en   (ordset_en),
    .data_en     (data_en),
    .ordset_vld  (ordset_vld),
    .ordset_type (ordset_type),
    .corrupt_idx (corrupt_idx),
    .hrst_det    (hrst_det)
  );

  // payload symbols to bytes
  ucpd_rx_data_decode data_decode_i (
    .ucpd_clk (ucpd_clk),
    .ic_rst_n (ic_rst_n),
    .data_en  (data_en),
    .sym_vld  (sym_vld),
    .sym      (sym),
    .byte_vld (byte_vld),
    .byte_val (byte_val),
    .eop      (eop)
  );

  // software side
  ucpd_rx_buffer buffer_i (
    .ucpd_clk    (ucpd_clk),
    .ic_rst_n    (ic_rst_n),
    .rx_start    (rx_start),
    .byte_vld    (byte_vld),
    .byte_val    (byte_val),
    .eop         (eop),
    .rxdr_rd     (rxdr_rd),
    .rx_byte     (rx_byte),
    .rxne        (rxne),
    .rx_ovr      (rx_ovr),
    .msg_end     (msg_end),
    .rx_byte_cnt (rx_byte_cnt)
  );

endmodule

// ==== test/ucpd_rx_tb.sv ====
// --------------------
// self-checking testbench for the usb pd receive path
// bits go out bit 0 first with random idle gaps, software reads happen in tick
// --------------------
`timescale 1ns/1ps

module ucpd_rx_tb;

  localparam int CLK_PERIOD = 10;
  localparam int N_BYTES    = 8;
  // symbols per test, k-codes + payload + eop
  localparam int SYMS_T2    = 4 + 2 * N_BYTES + 1;
  localparam int SYMS_T3    = 20 * 4 + 4 + 4;
  localparam int SYMS_T4    = (4 + 2) + (4 + 2 + 1) + (4 + 2);
  localparam int SYMS_T5    = 4 + 4 + 1;
  localparam int SYMS_T6    = 4 + 4;
  localparam int TOTAL_BITS = 5 * (SYMS_T2 + SYMS_T3 + SYMS_T4 + SYMS_T5 + SYMS_T6);
  localparam int WATCHDOG_NS = (TOTAL_BITS * 20 + 500) * CLK_PERIOD;

  localparam logic [4:0] S1  = ucpd_rx_pkg::KSYNC1;
  localparam logic [4:0] S2  = ucpd_rx_pkg::KSYNC2;
  localparam logic [4:0] S3  = ucpd_rx_pkg::KSYNC3;
  localparam logic [4:0] R1  = ucpd_rx_pkg::KRST1;
  localparam logic [4:0] R2  = ucpd_rx_pkg::KRST2;
  localparam logic [4:0] BAD = 5'b11110;   // data symbol, never a k-code
  // ordered set patterns in type order, position 1 first
  localparam logic [4:0] PAT [7][4] = '{
    '{S1, S1, S1, S2}, '{S1, S1, S3, S3}, '{S1, S3, S1, S3}, '{S1, R2, R2, S3},
    '{S1, R2, S3, S2}, '{R1, S1, R1, S3}, '{R1, R1, R1, R2}};
  // 4b5b encode, nibble 0 to f
  localparam logic [4:0] ENC [16] = '{
    5'b11110, 5'b01001, 5'b10100, 5'b10101, 5'b01010, 5'b01011, 5'b01110, 5'b01111,
    5'b10010, 5'b10011, 5'b10110, 5'b10111, 5'b11010, 5'b11011, 5'b11100, 5'b11101};

  logic                 ucpd_clk = 1'b0;
  logic                 ic_rst_n;
  logic                 rx_start;
  logic                 rx_bit_vld;
  logic                 rx_bit;
  logic [5:0]           ordset_en;
  logic                 rxdr_rd;
  logic [7:0]           rx_byte;
  logic                 rxne;
  logic                 rx_ovr;
  logic                 msg_end;
  logic [9:0]           rx_byte_cnt;
  logic                 ordset_vld;
  ucpd_rx_pkg::ordset_e ordset_type;
  logic [2:0]           corrupt_idx;
  logic                 hrst_det;

  integer               seed = 32'h5d3b;
  logic                 auto_read = 1'b1;   // software model reads every byte
  logic [7:0]           exp_q [$];          // bytes still to be read
  ucpd_rx_pkg::ordset_e os_type_seen;
  logic [2:0]           os_idx_seen;
  int err_cnt   = 0;
  int tests_ok  = 0;
  int tests_bad = 0;
  int os_cnt    = 0;
  int hrst_cnt  = 0;
  int msg_cnt   = 0;
  int rxne_cnt  = 0;   // falling edges with rxne high
  int read_cnt  = 0;
  int err_b;
  int os_b;
  int hrst_b;
  int msg_b;
  int rxne_b;
  int read_b;

  always #(CLK_PERIOD / 2) ucpd_clk = ~ucpd_clk;

  ucpd_rx_top dut_i (.*);

  // pulse monitor, outputs are stable at the falling edge
  always @(negedge ucpd_clk) begin
    if (ic_rst_n) begin
      if (ordset_vld) begin
        os_cnt++;
        os_type_seen = ordset_type;
        os_idx_seen  = corrupt_idx;
      end
      if (hrst_det) hrst_cnt++;
      if (msg_end) msg_cnt++;
      if (rxne) rxne_cnt++;
    end
  end

  // protocol rules --------------------
  assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n) ordset_vld |-> !hrst_det)
    else begin
      $display("CHECK FAILED t=%0t hrst_det got 1 exp 0 with ordset_vld", $time);
      err_cnt++;
    end
  assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n) ordset_vld |-> corrupt_idx <= 3'd4)
    else begin
      $display("CHECK FAILED t=%0t corrupt_idx got %0d exp 0 to 4", $time, $sampled(corrupt_idx));
      err_cnt++;
    end
  assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n) msg_end |=> !msg_end)
    else begin
      $display("CHECK FAILED t=%0t msg_end got 1 exp 0 in second cycle", $time);
      err_cnt++;
    end
  assert property (@(posedge ucpd_clk) disable iff (!ic_rst_n) $rose(rx_ovr) |-> rxne)
    else begin
      $display("CHECK FAILED t=%0t rxne got 0 exp 1 when rx_ovr rose", $time);
      err_cnt++;
    end

  // tasks --------------------
  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED t=%0t %s got %0h exp %0h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic report_error(input string what);
    $display("ERROR t=%0t %s", $time, what);
    err_cnt++;
  endtask

  // one cycle, pulses drop, then the software read model
  task automatic tick();
    @(negedge ucpd_clk);
    rx_start   = 1'b0;
    rx_bit_vld = 1'b0;
    rxdr_rd    = 1'b0;
    if (auto_read && rxne) begin
      if (exp_q.size() == 0) begin
        report_error("rx_byte holds a byte that no payload should have produced");
      end else begin
        check_val("rx_byte", rx_byte, exp_q.pop_front());
      end
      rxdr_rd = 1'b1;
      read_cnt++;
    end
  endtask

  task automatic send_start();
    tick();
    rx_start = 1'b1;
    tick();
  endtask

  task automatic send_bit(input logic b);
    int gap;
    gap = $unsigned($random(seed)) % 3;   // 0 to 2 idle cycles
    repeat (gap) tick();
    tick();
    rx_bit     = b;
    rx_bit_vld = 1'b1;
  endtask

  task automatic send_sym(input logic [4:0] s);
    for (int i = 0; i < 5; i++) send_bit(s[i]);
  endtask

  // bad marks the positions that get a non k-code symbol
  task automatic send_ordset(input int t, input logic [3:0] bad);
    for (int p = 0; p < ucpd_rx_pkg::SOP_KCODES; p++) begin
      send_sym(bad[p] ? BAD : PAT[t][p]);
    end
  endtask

  task automatic send_byte(input logic [7:0] b, input logic expect_it);
    if (expect_it) exp_q.push_back(b);
    send_sym(ENC[b[3:0]]);                // low nibble first
    send_sym(ENC[b[7:4]]);
  endtask

  task automatic end_msg();
    int n;
    send_sym(ucpd_rx_pkg::KEOP);
    n = 0;
    while (!msg_end && n < 40) begin
      tick();
      n++;
    end
    if (!msg_end) report_error("msg_end did not follow the EOP K-code");
  endtask

  task automatic settle();
    repeat (4) tick();
  endtask

  task automatic start_test();
    err_b  = err_cnt;
    os_b   = os_cnt;
    hrst_b = hrst_cnt;
    msg_b  = msg_cnt;
    rxne_b = rxne_cnt;
    read_b = read_cnt;
  endtask

  task automatic end_test(input string name);
    if (err_cnt == err_b) begin
      tests_ok++;
      $display("[%0t] test %s: ok", $time, name);
    end else begin
      tests_bad++;
      $display("[%0t] test %s: %0d check(s) failed", $time, name, err_cnt - err_b);
    end
  endtask

  // watchdog, bound from the bit count of all tests
  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Simulation failed");
    $finish;
  end

  // main sequence --------------------
  initial begin
    logic [7:0] b;
    logic [7:0] b1;
    int         k;
    ic_rst_n   = 1'b0;
    rx_start   = 1'b0;
    rx_bit_vld = 1'b0;
    rx_bit     = 1'b0;
    rxdr_rd    = 1'b0;
    ordset_en  = '1;
    repeat (5) @(negedge ucpd_clk);
    ic_rst_n = 1'b1;
    for (int n = 0; n < 16; n++) begin    // encode table against package decode
      if (ucpd_rx_pkg::decode_4b5b(ENC[n]) != 4'(n)) report_error("encode table mismatch");
    end

    start_test();
    tick();
    check_val("ordset_vld", ordset_vld, 0);
    check_val("hrst_det", hrst_det, 0);
    check_val("rxne", rxne, 0);
    check_val("rx_ovr", rx_ovr, 0);
    check_val("msg_end", msg_end, 0);
    check_val("data_en", dut_i.data_en, 0);
    check_val("rx_byte", rx_byte, 0);
    check_val("rx_byte_cnt", rx_byte_cnt, 0);
    end_test("reset state");

    start_test();
    send_start();
    send_ordset(0, 4'b0000);
    for (int i = 0; i < N_BYTES; i++) begin
      b = 8'($random(seed));
      send_byte(b, 1'b1);
    end
    end_msg();
    settle();
    check_val("ordset_vld pulses", os_cnt - os_b, 1);
    check_val("ordset_type", os_type_seen, ucpd_rx_pkg::os_sop);
    check_val("corrupt_idx", os_idx_seen, 0);
    check_val("bytes read", read_cnt - read_b, N_BYTES);
    check_val("rx_byte_cnt", rx_byte_cnt, N_BYTES);
    check_val("msg_end pulses", msg_cnt - msg_b, 1);
    check_val("rx_ovr", rx_ovr, 0);
    end_test("clean sop with payload");

    start_test();
    for (int t = 0; t < 5; t++) begin
      for (int p = 1; p <= 4; p++) begin
        k = os_cnt;
        send_start();
        send_ordset(t, 4'(1 << (p - 1)));
        settle();
        check_val("ordset_vld pulses", os_cnt - k, 1);
        check_val("ordset_type", os_type_seen, t);
        check_val("corrupt_idx", os_idx_seen, p);
      end
    end
    k = os_cnt;
    send_start();
    send_ordset(0, 4'b1001);               // two bad k-codes
    send_byte(8'h5a, 1'b0);
    send_byte(8'hc3, 1'b0);
    settle();
    check_val("ordset_vld pulses", os_cnt - k, 0);
    check_val("corrupt_idx", corrupt_idx, 7);
    check_val("ordset_type", ordset_type, ucpd_rx_pkg::os_invalid);
    check_val("rx_byte_cnt", rx_byte_cnt, 0);
    check_val("rxne cycles", rxne_cnt - rxne_b, 0);
    end_test("corrupted k-codes");

    start_test();
    send_start();
    send_ordset(6, 4'b0000);
    send_byte(8'h11, 1'b0);
    settle();
    check_val("hrst_det pulses", hrst_cnt - hrst_b, 1);
    check_val("ordset_vld pulses", os_cnt - os_b, 0);
    check_val("rx_byte_cnt", rx_byte_cnt, 0);
    check_val("rxne cycles", rxne_cnt - rxne_b, 0);
    b = 8'($random(seed));
    send_start();
    send_ordset(5, 4'b0000);
    send_byte(b, 1'b1);
    end_msg();
    settle();
    check_val("ordset_vld pulses", os_cnt - os_b, 1);
    check_val("ordset_type", os_type_seen, ucpd_rx_pkg::os_cable_rst);
    check_val("hrst_det pulses", hrst_cnt - hrst_b, 1);
    check_val("rx_byte_cnt", rx_byte_cnt, 1);
    check_val("bytes left unread", exp_q.size(), 0);
    k = rxne_cnt;
    ordset_en = 6'b011111;                 // cable reset masked
    send_start();
    send_ordset(5, 4'b0000);
    send_byte(8'h3c, 1'b0);
    settle();
    ordset_en = '1;
    check_val("ordset_vld pulses", os_cnt - os_b, 1);
    check_val("rxne cycles", rxne_cnt - k, 0);
    check_val("rx_byte_cnt", rx_byte_cnt, 0);
    end_test("reset ordered sets");

    start_test();
    auto_read = 1'b0;
    b  = 8'($random(seed));
    b1 = 8'($random(seed));
    send_start();
    send_ordset(0, 4'b0000);
    send_byte(b, 1'b0);
    send_byte(b1, 1'b0);                   // overwrites the unread byte
    end_msg();
    settle();
    check_val("rxne", rxne, 1);
    check_val("rx_ovr", rx_ovr, 1);
    check_val("rx_byte", rx_byte, b1);
    check_val("rx_byte_cnt", rx_byte_cnt, 2);
    tick();
    rxdr_rd = 1'b1;
    tick();
    tick();
    check_val("rxne", rxne, 0);
    check_val("rx_ovr", rx_ovr, 1);        // sticky past the read
    send_start();
    tick();
    check_val("rx_ovr", rx_ovr, 0);
    check_val("rx_byte_cnt", rx_byte_cnt, 0);
    auto_read = 1'b1;
    end_test("flags and overflow");

    start_test();
    ordset_en = 6'b111110;                 // sop masked
    send_start();
    send_ordset(0, 4'b0000);
    send_byte(8'h96, 1'b0);
    send_byte(8'h69, 1'b0);
    settle();
    ordset_en = '1;
    check_val("ordset_vld pulses", os_cnt - os_b, 0);
    check_val("rxne cycles", rxne_cnt - rxne_b, 0);
    check_val("rx_byte_cnt", rx_byte_cnt, 0);
    end_test("disabled type");

    $display("tests ok %0d, tests failed %0d, checks failed %0d", tests_ok, tests_bad, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
logic/ucpd_rx_pkg.sv
logic/ucpd_rx_symbol_shifter.sv
logic/ucpd_rx_sop_detect.sv
logic/ucpd_rx_data_decode.sv
logic/ucpd_rx_buffer.sv
logic/ucpd_rx_top.sv
test/ucpd_rx_tb.sv
